/* all.f */
design/cdc_fifo_pkg.sv
design/gray_ptr_sync.sv
design/credit_counter.sv
design/push_ctrl.sv
design/pop_ctrl.sv
design/flop_ram_1r1w.sv
design/cdc_fifo_flops_push_credit.sv
verification/cdc_fifo_tb.sv

/* design/cdc_fifo_flops_push_credit.sv */
`timescale 1ns/10ps

module cdc_fifo_flops_push_credit (
  input  logic                         push_clk,
  input  logic                         push_rst,
  input  logic                         pop_clk,
  input  logic                         pop_rst,
  // Push side
  input  logic                         push_credit_stall,
  output logic                         push_credit,
  input  logic                         push_valid,
  input  cdc_fifo_pkg::data_t          push_data,
  // Pop side
  input  logic                         pop_ready,
  output logic                         pop_valid,
  output cdc_fifo_pkg::data_t          pop_data,
  // Status
  output cdc_fifo_pkg::push_status_t   push_status,
  output cdc_fifo_pkg::pop_status_t    pop_status,
  output cdc_fifo_pkg::credit_status_t credit_status,
  // Credit setup, sampled during push reset
  input  cdc_fifo_pkg::credit_t        credit_initial_push,
  input  cdc_fifo_pkg::credit_t        credit_withhold_push
);

  // Pointers in their own domain and as seen by the other one
  cdc_fifo_pkg::ptr_t wr_ptr;
  cdc_fifo_pkg::ptr_t wr_ptr_sync;
  cdc_fifo_pkg::ptr_t rd_ptr;
  cdc_fifo_pkg::ptr_t rd_ptr_sync;
  cdc_fifo_pkg::ram_wr_t ram_wr;
  cdc_fifo_pkg::ram_rd_t ram_rd;
  cdc_fifo_pkg::data_t rd_data;
  cdc_fifo_pkg::count_t freed_slots;

  // ---------------------------------------------------------------------
  // Push domain
  // ---------------------------------------------------------------------

  push_ctrl push_ctrl (
    .push_clk    (push_clk),
    .push_rst    (push_rst),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_ptr      (wr_ptr),
    .ram_wr      (ram_wr),
    .freed_slots (freed_slots),
    .push_status (push_status)
  );

  credit_counter credit_counter (
    .push_clk             (push_clk),
    .push_rst             (push_rst),
    .credit_initial_push  (credit_initial_push),
    .credit_withhold_push (credit_withhold_push),
    .freed_slots          (freed_slots),
    .credit_stall         (push_credit_stall),
    .push_credit          (push_credit),
    .credit_status        (credit_status)
  );

  // ---------------------------------------------------------------------
  // Crossings and storage
  // ---------------------------------------------------------------------

  // Write pointer into the pop domain
  gray_ptr_sync gray_ptr_sync_wr (
    .src_clk (push_clk),
    .src_rst (push_rst),
    .dst_clk (pop_clk),
    .dst_rst (pop_rst),
    .src_ptr (wr_ptr),
    .dst_ptr (wr_ptr_sync)
  );

  // Read pointer back into the push domain, which returns the credits
  gray_ptr_sync gray_ptr_sync_rd (
    .src_clk (pop_clk),
    .src_rst (pop_rst),
    .dst_clk (push_clk),
    .dst_rst (push_rst),
    .src_ptr (rd_ptr),
    .dst_ptr (rd_ptr_sync)
  );

  flop_ram_1r1w flop_ram_1r1w (
    .wr_clk  (push_clk),
    .rd_clk  (pop_clk),
    .ram_wr  (ram_wr),
    .ram_rd  (ram_rd),
    .rd_data (rd_data)
  );

  // ---------------------------------------------------------------------
  // Pop domain
  // ---------------------------------------------------------------------

  pop_ctrl pop_ctrl (
    .pop_clk     (pop_clk),
    .pop_rst     (pop_rst),
    .pop_ready   (pop_ready),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_data     (rd_data),
    .rd_ptr      (rd_ptr),
    .ram_rd      (ram_rd),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_status  (pop_status)
  );

endmodule

/* design/cdc_fifo_pkg.sv */
package cdc_fifo_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------

  // Number of FIFO entries, a power of two so the pointers wrap cleanly
  localparam int DEPTH = 8;
  localparam int WIDTH = 16;
  // Flops per synchronizer chain in the destination domain
  localparam int NUM_SYNC_STAGES = 3;
  localparam int ADDR_WIDTH = 3;
  // One extra wrap bit tells a full FIFO from an empty one
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;
  // Counts run from 0 to DEPTH inclusive
  localparam int COUNT_WIDTH = 4;
  // The maximum credit equals DEPTH
  localparam int CREDIT_WIDTH = 4;

  typedef logic [WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [PTR_WIDTH-1:0] ptr_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // ---------------------------------------------------------------------
  // RAM requests and status words
  // ---------------------------------------------------------------------

  // Write request from the push side, applied on the same push edge
  typedef struct packed {
    logic valid;
    addr_t addr;
    data_t data;
  } ram_wr_t;

  // Read request from the pop side, data returns one pop cycle later
  typedef struct packed {
    logic valid;
    addr_t addr;
  } ram_rd_t;

  typedef struct packed {
    logic full;
    logic full_next;
    count_t slots;
    count_t slots_next;
  } push_status_t;

  typedef struct packed {
    logic empty;
    logic empty_next;
    count_t items;
    count_t items_next;
  } pop_status_t;

  typedef struct packed {
    credit_t count;
    credit_t available;
  } credit_status_t;

endpackage

/* design/credit_counter.sv */
`timescale 1ns/10ps

module credit_counter (
  input  logic                         push_clk,
  input  logic                         push_rst,
  input  cdc_fifo_pkg::credit_t        credit_initial_push,
  input  cdc_fifo_pkg::credit_t        credit_withhold_push,
  input  cdc_fifo_pkg::count_t         freed_slots,
  input  logic                         credit_stall,
  output logic                         push_credit,
  output cdc_fifo_pkg::credit_status_t credit_status
);

  // Credits still held by the block, not yet granted to the sender
  cdc_fifo_pkg::credit_t count;
  cdc_fifo_pkg::credit_t count_next;
  cdc_fifo_pkg::credit_t available;
  // Low during reset and for the first cycle after it
  logic active;

  // ---------------------------------------------------------------------
  // Credit issue
  // ---------------------------------------------------------------------

  // The withheld part of the count is never granted
  // When withhold exceeds the count nothing is available at all
  assign available = (count > credit_withhold_push) ?
                     count - credit_withhold_push : '0;

  // At most one credit leaves per push cycle
  assign push_credit = active && (available != '0) && !credit_stall;

  // ---------------------------------------------------------------------
  // Counter update
  // ---------------------------------------------------------------------

  // Slots freed by pops come back as credit; an issued credit is spent
  assign count_next = count + cdc_fifo_pkg::credit_t'(freed_slots)
                    - cdc_fifo_pkg::credit_t'(push_credit);

  always_ff @(posedge push_clk) begin
    if (push_rst) begin
      // Loaded every reset cycle, so the last reset cycle's value sticks
      count  <= credit_initial_push;
      active <= 1'b0;
    end else begin
      count  <= count_next;
      active <= 1'b1;
    end
  end

  assign credit_status.count     = count;
  assign credit_status.available = available;

  // Freed slots plus credits held can never exceed the number of entries,
  // which only holds if the read pointer crossing reports every pop once
  a_count_max: assert property (@(posedge push_clk) disable iff (push_rst)
    count <= cdc_fifo_pkg::CREDIT_WIDTH'(cdc_fifo_pkg::DEPTH));

endmodule

/* design/flop_ram_1r1w.sv */
`timescale 1ns/10ps

module flop_ram_1r1w (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  cdc_fifo_pkg::ram_wr_t ram_wr,
  input  cdc_fifo_pkg::ram_rd_t ram_rd,
  output cdc_fifo_pkg::data_t   rd_data
);

  // Storage cells, written in the push domain and read in the pop domain
  cdc_fifo_pkg::data_t mem [cdc_fifo_pkg::DEPTH];

  // ---------------------------------------------------------------------
  // Write port
  // ---------------------------------------------------------------------

  // A cell is always written before the pop side can see it
  always_ff @(posedge wr_clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ---------------------------------------------------------------------
  // Read port
  // ---------------------------------------------------------------------

  // Read data is registered and holds between reads
  always_ff @(posedge rd_clk) begin
    if (ram_rd.valid) begin
      rd_data <= mem[ram_rd.addr];
    end
  end

endmodule

/* design/gray_ptr_sync.sv */
`timescale 1ns/10ps

module gray_ptr_sync (
  input  logic               src_clk,
  input  logic               src_rst,
  input  logic               dst_clk,
  input  logic               dst_rst,
  input  cdc_fifo_pkg::ptr_t src_ptr,
  output cdc_fifo_pkg::ptr_t dst_ptr
);

  // Gray copy of the source pointer, held in a flop so only one bit can toggle
  cdc_fifo_pkg::ptr_t src_gray;
  // Synchronizer chain, element 0 is the first flop that may go metastable
  cdc_fifo_pkg::ptr_t sync_q [cdc_fifo_pkg::NUM_SYNC_STAGES];

  // ---------------------------------------------------------------------
  // Source domain
  // ---------------------------------------------------------------------

  always_ff @(posedge src_clk) begin
    if (src_rst) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_ptr ^ (src_ptr >> 1);
    end
  end

  // ---------------------------------------------------------------------
  // Destination domain
  // ---------------------------------------------------------------------

  always_ff @(posedge dst_clk) begin
    if (dst_rst) begin
      for (int i = 0; i < cdc_fifo_pkg::NUM_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= src_gray;
      for (int i = 1; i < cdc_fifo_pkg::NUM_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Back to binary, each bit is the XOR of all Gray bits at or above it
  always_comb begin
    for (int i = 0; i < cdc_fifo_pkg::PTR_WIDTH; i++) begin
      dst_ptr[i] = ^(sync_q[cdc_fifo_pkg::NUM_SYNC_STAGES-1] >> i);
    end
  end

  // The crossing is only safe if the source pointer moves by one step at most
  a_gray_one_bit: assert property (@(posedge src_clk) disable iff (src_rst)
    $countones(src_gray ^ $past(src_gray)) <= 1);

endmodule

/* design/pop_ctrl.sv */
`timescale 1ns/10ps

module pop_ctrl (
  input  logic                      pop_clk,
  input  logic                      pop_rst,
  input  logic                      pop_ready,
  input  cdc_fifo_pkg::ptr_t        wr_ptr_sync,
  input  cdc_fifo_pkg::data_t       rd_data,
  output cdc_fifo_pkg::ptr_t        rd_ptr,
  output cdc_fifo_pkg::ram_rd_t     ram_rd,
  output logic                      pop_valid,
  output cdc_fifo_pkg::data_t       pop_data,
  output cdc_fifo_pkg::pop_status_t pop_status
);

  // IDLE waits for data, READ waits on the RAM, HOLD presents the output
  typedef enum logic [1:0] {
    IDLE,
    READ,
    HOLD
  } state_t;

  state_t state;
  state_t state_next;
  // RAM read pointer runs one step ahead of rd_ptr while a word is in flight
  cdc_fifo_pkg::ptr_t ram_ptr;
  cdc_fifo_pkg::ptr_t ram_ptr_next;
  // The read pointer sent to the push side moves only when a word is popped
  cdc_fifo_pkg::ptr_t rd_ptr_next;
  // Write pointer delayed by one cycle for status reporting
  cdc_fifo_pkg::ptr_t wr_ptr_q;
  cdc_fifo_pkg::count_t items;
  cdc_fifo_pkg::count_t items_next;
  // Set when the RAM still holds an entry that has not been read
  logic avail;
  logic issue;
  logic xfer;

  assign avail = (wr_ptr_sync != ram_ptr);
  assign xfer  = pop_valid && pop_ready;

  // ---------------------------------------------------------------------
  // Read FSM
  // ---------------------------------------------------------------------

  always_comb begin
    state_next = state;
    issue      = 1'b0;
    case (state)
      IDLE: begin
        if (avail) begin
          issue      = 1'b1;
          state_next = READ;
        end
      end
      // The RAM output is valid here and gets captured on this edge
      READ: state_next = HOLD;
      HOLD: begin
        if (xfer) begin
          issue      = avail;
          state_next = avail ? READ : IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  assign ram_ptr_next = ram_ptr + cdc_fifo_pkg::ptr_t'(issue);
  assign rd_ptr_next  = rd_ptr + cdc_fifo_pkg::ptr_t'(xfer);
  assign ram_rd.valid = issue;
  assign ram_rd.addr  = ram_ptr[cdc_fifo_pkg::ADDR_WIDTH-1:0];

  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      state     <= IDLE;
      ram_ptr   <= '0;
      rd_ptr    <= '0;
      wr_ptr_q  <= '0;
      pop_valid <= 1'b0;
    end else begin
      state     <= state_next;
      ram_ptr   <= ram_ptr_next;
      rd_ptr    <= rd_ptr_next;
      wr_ptr_q  <= wr_ptr_sync;
      pop_valid <= (state_next == HOLD);
    end
  end

  // Output data register, loaded only from the RAM read port
  always_ff @(posedge pop_clk) begin
    if (state == READ) begin
      pop_data <= rd_data;
    end
  end

  // ---------------------------------------------------------------------
  // Status
  // ---------------------------------------------------------------------

  // Every entry not yet popped counts, including the one in the output register
  assign items      = cdc_fifo_pkg::count_t'(wr_ptr_q - rd_ptr);
  assign items_next = cdc_fifo_pkg::count_t'(wr_ptr_sync - rd_ptr_next);

  assign pop_status.items      = items;
  assign pop_status.items_next = items_next;
  assign pop_status.empty      = (items == '0);
  assign pop_status.empty_next = (items_next == '0);

  // Offered data must hold until the consumer takes it
  a_pop_stable: assert property (@(posedge pop_clk) disable iff (pop_rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

/* design/push_ctrl.sv */
`timescale 1ns/10ps

module push_ctrl (
  input  logic                       push_clk,
  input  logic                       push_rst,
  input  logic                       push_valid,
  input  cdc_fifo_pkg::data_t        push_data,
  input  cdc_fifo_pkg::ptr_t         rd_ptr_sync,
  output cdc_fifo_pkg::ptr_t         wr_ptr,
  output cdc_fifo_pkg::ram_wr_t      ram_wr,
  output cdc_fifo_pkg::count_t       freed_slots,
  output cdc_fifo_pkg::push_status_t push_status
);

  cdc_fifo_pkg::ptr_t wr_ptr_next;
  // Read pointer as last seen in this domain
  cdc_fifo_pkg::ptr_t rd_ptr_q;
  cdc_fifo_pkg::count_t occupancy;
  cdc_fifo_pkg::count_t occupancy_next;

  // ---------------------------------------------------------------------
  // Write path
  // ---------------------------------------------------------------------

  // The sender only pushes with a credit in hand, so no full check here
  assign wr_ptr_next = wr_ptr + cdc_fifo_pkg::ptr_t'(push_valid);

  // The RAM takes the write on the same edge as the push
  assign ram_wr.valid = push_valid;
  assign ram_wr.addr  = wr_ptr[cdc_fifo_pkg::ADDR_WIDTH-1:0];
  assign ram_wr.data  = push_data;

  always_ff @(posedge push_clk) begin
    if (push_rst) begin
      wr_ptr   <= '0;
      rd_ptr_q <= '0;
    end else begin
      wr_ptr   <= wr_ptr_next;
      rd_ptr_q <= rd_ptr_sync;
    end
  end

  // ---------------------------------------------------------------------
  // Freed slots and status
  // ---------------------------------------------------------------------

  // The synchronized pointer may jump by several steps in one push cycle
  assign freed_slots = cdc_fifo_pkg::count_t'(rd_ptr_sync - rd_ptr_q);

  // Wrap-bit arithmetic gives the occupancy directly
  assign occupancy      = cdc_fifo_pkg::count_t'(wr_ptr - rd_ptr_q);
  assign occupancy_next = cdc_fifo_pkg::count_t'(wr_ptr_next - rd_ptr_sync);

  assign push_status.slots      = cdc_fifo_pkg::count_t'(cdc_fifo_pkg::DEPTH) - occupancy;
  assign push_status.slots_next = cdc_fifo_pkg::count_t'(cdc_fifo_pkg::DEPTH) - occupancy_next;
  assign push_status.full       = (occupancy == cdc_fifo_pkg::count_t'(cdc_fifo_pkg::DEPTH));
  assign push_status.full_next  = (occupancy_next == cdc_fifo_pkg::count_t'(cdc_fifo_pkg::DEPTH));

  // A push into a full FIFO means the sender pushed without a credit
  a_no_push_full: assert property (@(posedge push_clk) disable iff (push_rst)
    push_valid |-> !push_status.full);

endmodule

/* run.sh */
#!/bin/sh
# Builds the simulation with Verilator and runs it, exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module cdc_fifo_tb -f all.f -o cdc_fifo_sim &&
  ./obj_dir/cdc_fifo_sim ||
  exit 1

/* verification/cdc_fifo_tb.sv */
`timescale 1ns/10ps

module cdc_fifo_tb;

  typedef enum logic [1:0] {
    READY_ALWAYS,
    READY_RANDOM,
    READY_HOLD
  } ready_mode_t;

  // One row of the stimulus table
  typedef struct packed {
    cdc_fifo_pkg::credit_t credit_init;
    cdc_fifo_pkg::credit_t withhold;
    logic [7:0]            words;
    ready_mode_t           ready_mode;
    logic [7:0]            stall_start;
    logic [7:0]            stall_len;
  } stim_row_t;

  localparam int NUM_ROWS = 5;
  localparam int TIMEOUT = 3000;
  localparam int SETTLE = 60;
  localparam logic [31:0] SEED = 32'd37215;

  logic push_clk;
  logic pop_clk;
  logic push_rst;
  logic pop_rst;
  logic push_credit_stall;
  logic push_credit;
  logic push_valid;
  cdc_fifo_pkg::data_t push_data;
  logic pop_ready;
  logic pop_valid;
  cdc_fifo_pkg::data_t pop_data;
  cdc_fifo_pkg::push_status_t push_status;
  cdc_fifo_pkg::pop_status_t pop_status;
  cdc_fifo_pkg::credit_status_t credit_status;
  cdc_fifo_pkg::credit_t credit_initial_push;
  cdc_fifo_pkg::credit_t credit_withhold_push;

  stim_row_t rows [NUM_ROWS];
  // Row in force, as seen by the clocked stimulus processes
  stim_row_t cur_row;
  ready_mode_t ready_mode;
  logic send_en;
  logic [31:0] data_rng;
  logic [31:0] ready_rng;
  // Scoreboard of every word pushed in the current row, in order
  cdc_fifo_pkg::data_t sb_q [$];
  int credits_received;
  int credits_used;
  int push_count;
  int pop_count;
  int cycle_idx;
  logic hold_prev;
  cdc_fifo_pkg::data_t data_prev;
  // Next-cycle status as reported one cycle earlier
  logic push_next_ok;
  cdc_fifo_pkg::count_t slots_next_prev;
  logic full_next_prev;
  logic pop_next_ok;
  cdc_fifo_pkg::count_t items_next_prev;
  logic empty_next_prev;

  cdc_fifo_flops_push_credit uut (
    .push_clk             (push_clk),
    .push_rst             (push_rst),
    .pop_clk              (pop_clk),
    .pop_rst              (pop_rst),
    .push_credit_stall    (push_credit_stall),
    .push_credit          (push_credit),
    .push_valid           (push_valid),
    .push_data            (push_data),
    .pop_ready            (pop_ready),
    .pop_valid            (pop_valid),
    .pop_data             (pop_data),
    .push_status          (push_status),
    .pop_status           (pop_status),
    .credit_status        (credit_status),
    .credit_initial_push  (credit_initial_push),
    .credit_withhold_push (credit_withhold_push)
  );

  // Periods 40 ns and 56 ns never share a falling push edge with a rising pop edge
  always #20 push_clk = ~push_clk;
  always #28 pop_clk = ~pop_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic value_error(input string name, input int got, input int exp);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    $display("Checks failed");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic other_error(input string what);
    $display("at %0t ns: %s", $time, what);
    $display("Checks failed");
    $fatal(1, "%s", what);
  endtask

  // ---------------------------------------------------------------------
  // Sender model and stall window, push domain
  // ---------------------------------------------------------------------

  // Credits are counted mid-cycle where push_credit is settled
  always @(negedge push_clk) begin
    if (push_rst) begin
      credits_received <= 0;
      push_next_ok     <= 1'b0;
    end else begin
      assert (!(push_credit_stall && push_credit))
        else other_error("a credit was issued while push_credit_stall was high");
      // What was reported as next cycle's status must be what shows now
      if (push_next_ok) begin
        assert (slots_next_prev == push_status.slots)
          else value_error("push_slots_next", int'(slots_next_prev), int'(push_status.slots));
        assert (full_next_prev == push_status.full)
          else value_error("push_full_next", int'(full_next_prev), int'(push_status.full));
      end
      if (push_credit) begin
        credits_received <= credits_received + 1;
      end
      push_next_ok    <= 1'b1;
      slots_next_prev <= push_status.slots_next;
      full_next_prev  <= push_status.full_next;
    end
  end

  // A word goes out only while a credit is held and words remain
  always @(posedge push_clk) begin
    if (push_rst) begin
      push_valid   <= 1'b0;
      credits_used <= 0;
      push_count   <= 0;
      sb_q.delete();
    end else if (send_en && credits_received > credits_used
                 && push_count < int'(cur_row.words)) begin
      push_valid   <= 1'b1;
      push_data    <= data_rng[15:0];
      sb_q.push_back(data_rng[15:0]);
      data_rng     <= xorshift(data_rng);
      credits_used <= credits_used + 1;
      push_count   <= push_count + 1;
    end else begin
      push_valid <= 1'b0;
    end
  end

  always @(posedge push_clk) begin
    if (push_rst) begin
      cycle_idx         <= 0;
      push_credit_stall <= 1'b0;
    end else begin
      cycle_idx         <= cycle_idx + 1;
      push_credit_stall <= cycle_idx >= int'(cur_row.stall_start)
                        && cycle_idx < int'(cur_row.stall_start) + int'(cur_row.stall_len);
    end
  end

  // ---------------------------------------------------------------------
  // Consumer and scoreboard, pop domain
  // ---------------------------------------------------------------------

  always @(posedge pop_clk) begin
    if (pop_rst) begin
      pop_ready <= 1'b0;
    end else begin
      case (ready_mode)
        READY_ALWAYS: pop_ready <= 1'b1;
        READY_RANDOM: begin
          pop_ready <= ready_rng[4];
          ready_rng <= xorshift(ready_rng);
        end
        default: pop_ready <= 1'b0;
      endcase
    end
  end

  // A transfer seen here completes on the next rising pop edge
  always @(negedge pop_clk) begin
    if (pop_rst) begin
      pop_count   <= 0;
      hold_prev   <= 1'b0;
      pop_next_ok <= 1'b0;
    end else begin
      if (hold_prev) begin
        assert (pop_valid) else value_error("pop_valid", int'(pop_valid), 1);
        assert (pop_data == data_prev)
          else value_error("pop_data", int'(pop_data), int'(data_prev));
      end
      if (pop_next_ok) begin
        assert (items_next_prev == pop_status.items)
          else value_error("pop_items_next", int'(items_next_prev), int'(pop_status.items));
        assert (empty_next_prev == pop_status.empty)
          else value_error("pop_empty_next", int'(empty_next_prev), int'(pop_status.empty));
      end
      if (pop_valid && pop_ready) begin
        assert (pop_count < sb_q.size())
          else other_error("a word was popped that was never pushed");
        assert (pop_data == sb_q[pop_count])
          else value_error("pop_data", int'(pop_data), int'(sb_q[pop_count]));
        pop_count <= pop_count + 1;
      end
      hold_prev       <= pop_valid && !pop_ready;
      data_prev       <= pop_data;
      pop_next_ok     <= 1'b1;
      items_next_prev <= pop_status.items_next;
      empty_next_prev <= pop_status.empty_next;
    end
  end

  // ---------------------------------------------------------------------
  // Row sequencing
  // ---------------------------------------------------------------------

  // Each domain is held in reset for at least 3 of its own cycles
  task automatic reset_dut(input stim_row_t row);
    @(posedge push_clk);
    push_rst             <= 1'b1;
    send_en              <= 1'b0;
    cur_row              <= row;
    ready_mode           <= row.ready_mode;
    credit_initial_push  <= row.credit_init;
    credit_withhold_push <= row.withhold;
    @(posedge pop_clk);
    pop_rst <= 1'b1;
    repeat (3) @(posedge pop_clk);
    pop_rst <= 1'b0;
    repeat (3) @(posedge push_clk);
    push_rst <= 1'b0;
  endtask

  task automatic run_row(input stim_row_t row);
    int cycles;
    int credit_target;
    int avail_init;
    // Every popped word returns its slot as a credit
    credit_target = int'(row.credit_init) - int'(row.withhold) + int'(row.words);
    // The withheld part is never offered
    avail_init = (row.credit_init > row.withhold) ?
                 int'(row.credit_init) - int'(row.withhold) : 0;

    // Idle state straight after reset
    @(negedge push_clk);
    assert (push_credit == 1'b0) else value_error("push_credit", int'(push_credit), 0);
    assert (pop_valid == 1'b0) else value_error("pop_valid", int'(pop_valid), 0);
    assert (pop_status.empty) else value_error("pop_empty", int'(pop_status.empty), 1);
    assert (int'(push_status.slots) == cdc_fifo_pkg::DEPTH)
      else value_error("push_slots", int'(push_status.slots), cdc_fifo_pkg::DEPTH);
    assert (credit_status.count == row.credit_init)
      else value_error("credit_count", int'(credit_status.count), int'(row.credit_init));
    assert (int'(credit_status.available) == avail_init)
      else value_error("credit_available", int'(credit_status.available), avail_init);
    @(posedge push_clk);
    send_en <= 1'b1;

    if (row.ready_mode == READY_HOLD) begin
      // Every slot filled and the first word parked in the output register
      cycles = 0;
      while (push_count < cdc_fifo_pkg::DEPTH) begin
        @(negedge push_clk);
        cycles++;
        if (cycles > TIMEOUT) other_error("timed out filling the FIFO under back-pressure");
      end
      @(negedge push_clk);
      cycles = 0;
      while (!pop_valid) begin
        @(negedge push_clk);
        cycles++;
        if (cycles > TIMEOUT) other_error("timed out waiting for pop_valid under back-pressure");
      end
      assert (push_status.full) else value_error("push_full", int'(push_status.full), 1);
      assert (push_status.slots == '0)
        else value_error("push_slots", int'(push_status.slots), 0);
      assert (pop_valid) else value_error("pop_valid", int'(pop_valid), 1);
      assert (pop_data == sb_q[0]) else value_error("pop_data", int'(pop_data), int'(sb_q[0]));
      repeat (SETTLE) @(negedge push_clk);
      assert (credits_received == int'(row.credit_init) - int'(row.withhold))
        else other_error("a credit arrived while the FIFO was full");
      assert (push_count == cdc_fifo_pkg::DEPTH)
        else value_error("words pushed", push_count, cdc_fifo_pkg::DEPTH);
      assert (push_status.full) else value_error("push_full", int'(push_status.full), 1);
      @(posedge push_clk);
      ready_mode <= READY_ALWAYS;
    end

    cycles = 0;
    while (pop_count < int'(row.words)) begin
      @(negedge push_clk);
      cycles++;
      if (cycles > TIMEOUT) other_error("timed out waiting for every pushed word to pop");
    end
    cycles = 0;
    while (credits_received < credit_target) begin
      @(negedge push_clk);
      cycles++;
      if (cycles > TIMEOUT) other_error("timed out waiting for the credits to return");
    end
    repeat (SETTLE) @(negedge push_clk);
    assert (credits_received == credit_target)
      else value_error("credit total", credits_received, credit_target);
    // Every credit has gone out again and only the withheld part stays behind
    assert (credit_status.count == row.withhold)
      else value_error("credit_count", int'(credit_status.count), int'(row.withhold));
    assert (credit_status.available == '0)
      else value_error("credit_available", int'(credit_status.available), 0);
    cycles = 0;
    while (int'(push_status.slots) != cdc_fifo_pkg::DEPTH) begin
      @(negedge push_clk);
      cycles++;
      if (cycles > TIMEOUT) other_error("timed out waiting for push_slots to recover");
    end
    assert (pop_status.empty) else value_error("pop_empty", int'(pop_status.empty), 1);
    assert (pop_status.items == '0)
      else value_error("pop_items", int'(pop_status.items), 0);
    assert (pop_valid == 1'b0) else value_error("pop_valid", int'(pop_valid), 0);
    assert (push_count == int'(row.words))
      else value_error("words pushed", push_count, int'(row.words));
    assert (pop_count == int'(row.words))
      else value_error("words popped", pop_count, int'(row.words));
  endtask

  initial begin
    push_clk             = 1'b0;
    pop_clk              = 1'b0;
    push_rst             = 1'b1;
    pop_rst              = 1'b1;
    push_credit_stall    = 1'b0;
    push_valid           = 1'b0;
    push_data            = '0;
    pop_ready            = 1'b0;
    credit_initial_push  = '0;
    credit_withhold_push = '0;
    send_en              = 1'b0;
    ready_mode           = READY_ALWAYS;
    cur_row              = '0;
    data_rng             = SEED;
    ready_rng            = xorshift(SEED);
    // Initial credit, withhold, words, pop_ready duty, stall start and length
    rows[0] = '{4'd8, 4'd0, 8'd40, READY_ALWAYS, 8'd0, 8'd0};
    rows[1] = '{4'd5, 4'd2, 8'd30, READY_RANDOM, 8'd10, 8'd20};
    rows[2] = '{4'd8, 4'd0, 8'd12, READY_HOLD, 8'd0, 8'd0};
    rows[3] = '{4'd7, 4'd3, 8'd0, READY_ALWAYS, 8'd0, 8'd0};
    rows[4] = '{4'd8, 4'd1, 8'd50, READY_RANDOM, 8'd3, 8'd12};
    for (int i = 0; i < NUM_ROWS; i++) begin
      reset_dut(rows[i]);
      run_row(rows[i]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule
